/* compile.f */
+incdir+src
+incdir+tb
src/fairq_pkg.sv
src/fairq_header_parser.sv
src/fairq_queue_lane.sv
src/fairq_window_rewriter.sv
src/fairq_top.sv
tb/fairq_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fairq testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module fairq_tb \
   -Mdir obj_dir -o fairq_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/fairq_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "sim passed" sim.log; then
   exit 0
else
   echo "pass message not found in sim.log"
   exit 1
fi

/* tb/fairq_tb_pkts.svh */
// packet table rows, table contents and the expansion of one row into stream words
`ifndef FAIRQ_TB_PKTS_SVH
`define FAIRQ_TB_PKTS_SVH

// tcp flag bits in word 6
localparam logic [7:0] F_FIN = 8'h01;
localparam logic [7:0] F_SYN = 8'h02;
localparam logic [7:0] F_RST = 8'h04;
localparam logic [7:0] F_ACK = 8'h10;

typedef enum logic [1:0] {ROW_CFG, ROW_TCP, ROW_UDP, ROW_ARP} row_kind_t;

// cfg rows use src as the queue number and cap as its capacity
typedef struct packed {
   row_kind_t    kind;
   queue_idx_t   src;
   queue_mask_t  dst;
   logic [15:0]  sport;
   logic [15:0]  dport;
   logic [7:0]   flags;
   sram_addr_t   cap;
   window_t      window;
   window_t      checksum;
   logic [31:0]  tail;
} row_t;

row_t        rows[$];
// the eight words of the row being sent
data_word_t  pkt_data [0:7];
ctrl_t       pkt_ctrl [0:7];

task automatic add_row(input row_kind_t kind, input int src, input logic [7:0] dst,
                       input int sport, input int dport, input logic [7:0] flags,
                       input int cap);
   row_t r;
   r.kind     = kind;
   r.src      = queue_idx_t'(src);
   r.dst      = dst;
   r.sport    = 16'(sport);
   r.dport    = 16'(dport);
   r.flags    = flags;
   r.cap      = sram_addr_t'(cap);
   // window, checksum and trailing bytes are random
   r.window   = window_t'($urandom);
   r.checksum = window_t'($urandom);
   r.tail     = $urandom;
   rows.push_back(r);
endtask

task automatic build_table();
   // nothing configured yet, ack goes through untouched
   add_row(ROW_TCP, 0, 8'h02, 5001, 40000, F_ACK, 0);
   add_row(ROW_CFG, 0, 8'h00, 0, 0, 8'h00, 'h1000);
   add_row(ROW_CFG, 1, 8'h00, 0, 0, 8'h00, 'h0800);
   add_row(ROW_CFG, 2, 8'h00, 0, 0, 8'h00, 'h2000);
   add_row(ROW_TCP, 0, 8'h02, 5001, 40000, F_ACK, 0);
   // pass-through kinds
   add_row(ROW_ARP, 0, 8'h02, 80, 1234, F_ACK, 0);
   add_row(ROW_UDP, 0, 8'h02, 80, 1234, F_ACK, 0);
   add_row(ROW_TCP, 0, 8'h02, 22, 40000, F_ACK, 0);
   add_row(ROW_TCP, 0, 8'h02, 80, 1234, F_SYN, 0);
   // syn-acks open flows on both ends
   add_row(ROW_TCP, 0, 8'h02, 80, 1234, F_SYN | F_ACK, 0);
   add_row(ROW_TCP, 2, 8'h01, 1234, 5001, F_SYN | F_ACK, 0);
   add_row(ROW_TCP, 0, 8'h02, 5001, 40000, F_ACK, 0);
   // multicast syn-ack is ignored
   add_row(ROW_TCP, 0, 8'h06, 80, 1234, F_SYN | F_ACK, 0);
   add_row(ROW_TCP, 0, 8'h02, 5001, 40000, F_ACK, 0);
   add_row(ROW_TCP, 1, 8'h04, 80, 1234, F_ACK, 0);
   // fins close on the destination queue
   add_row(ROW_TCP, 1, 8'h01, 80, 1234, F_FIN | F_ACK, 0);
   add_row(ROW_TCP, 0, 8'h02, 5001, 40000, F_ACK, 0);
   add_row(ROW_TCP, 3, 8'h02, 1234, 80, F_FIN, 0);
   add_row(ROW_TCP, 3, 8'h01, 80, 1234, F_ACK, 0);
   // large queue, window saturates
   add_row(ROW_CFG, 7, 8'h00, 0, 0, 8'h00, 'h40000);
   add_row(ROW_TCP, 7, 8'h01, 80, 1234, F_ACK, 0);
   // small queue, share floor
   add_row(ROW_CFG, 4, 8'h00, 0, 0, 8'h00, 'h0200);
   add_row(ROW_TCP, 4, 8'h01, 5001, 1234, F_ACK, 0);
   add_row(ROW_TCP, 2, 8'h01, 80, 1234, F_ACK, 0);
   add_row(ROW_TCP, 0, 8'h02, 80, 1234, F_RST | F_ACK, 0);
endtask

// header word, six data words, last word with window and checksum
task automatic expand_row(input row_t r);
   logic [15:0] ether;
   logic [7:0]  proto;
   ether = (r.kind == ROW_ARP) ? 16'h0806 : `FQ_ETHERTYPE_IP;
   proto = (r.kind == ROW_UDP) ? 8'd17 : `FQ_PROTO_TCP;
   pkt_data[0] = (data_word_t'(r.src) << `FQ_IOQ_SRC_POS) |
                 (data_word_t'(r.dst) << `FQ_IOQ_DST_POS);
   pkt_data[1] = 64'h0011_2233_4455_6677;
   pkt_data[2] = {32'h8899_aabb, ether, 16'h4500};
   pkt_data[3] = {56'h0034_1234_4000_40, proto};
   pkt_data[4] = 64'hc0a8_0001_c0a8_0002;
   pkt_data[5] = {16'h0002, r.sport, r.dport, 16'h0000};
   pkt_data[6] = {56'h0, r.flags};
   pkt_data[7] = {r.window, r.checksum, r.tail};
   pkt_ctrl[0] = `FQ_IOQ_CTRL;
   for (int w = 1; w < 7; w++) begin
      pkt_ctrl[w] = 8'h00;
   end
   pkt_ctrl[7] = 8'h80;
endtask

`endif

/* tb/fairq_tb.sv */
// testbench: clock, reset, table-driven packet loop, reference model, checks, timeout
`timescale 1ns/1ps
`default_nettype none

`include "fairq_defines.svh"

module fairq_tb;
   import fairq_pkg::*;

   logic         clk;
   logic         reset;
   logic         in_wr;
   ctrl_t        in_ctrl;
   data_word_t   in_data;
   logic         rd_dst_addr;
   queue_idx_t   dst_oq;
   sram_addr_t   dst_oq_high_addr;
   sram_addr_t   dst_oq_low_addr;
   logic         out_wr;
   ctrl_t        out_ctrl;
   data_word_t   out_data;

   // output expected after the last driven cycle
   logic         exp_wr;
   ctrl_t        exp_ctrl;
   data_word_t   exp_data;

   int           data_errors = 0;
   int           ctrl_errors = 0;
   int           valid_errors = 0;
   int           cycles = 0;
   int           cycle_limit = 0;

   // model state per queue
   sram_addr_t   model_cap [`FQ_NUM_QUEUES];
   int           model_open_src [`FQ_NUM_QUEUES];
   int           model_open_dst [`FQ_NUM_QUEUES];
   int           model_close [`FQ_NUM_QUEUES];
   // share has been computed at least once
   bit           model_live [`FQ_NUM_QUEUES];

   `include "fairq_tb_pkts.svh"

   fairq_top dut (
      .clk              (clk),
      .reset            (reset),
      .in_wr            (in_wr),
      .in_ctrl          (in_ctrl),
      .in_data          (in_data),
      .rd_dst_addr      (rd_dst_addr),
      .dst_oq           (dst_oq),
      .dst_oq_high_addr (dst_oq_high_addr),
      .dst_oq_low_addr  (dst_oq_low_addr),
      .out_wr           (out_wr),
      .out_ctrl         (out_ctrl),
      .out_data         (out_data)
   );

   always #20 clk = ~clk;

   // run length guard
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("timeout: run still going after %0d cycles", cycle_limit);
         $display("sim failed");
         $finish;
      end
   end

   //////////////////////////////
   // compare tasks
   //////////////////////////////
   task automatic check_data(input data_word_t got, input data_word_t expected);
      if (got !== expected) begin
         data_errors++;
         $display("Fail %0t ns: out_data %h, expected %h", $time, got, expected);
      end
   endtask

   task automatic check_ctrl(input ctrl_t got, input ctrl_t expected);
      if (got !== expected) begin
         ctrl_errors++;
         $display("Fail %0t ns: out_ctrl %h, expected %h", $time, got, expected);
      end
   endtask

   task automatic check_valid(input logic got, input logic expected);
      if (got !== expected) begin
         valid_errors++;
         if (expected) begin
            $display("output word missing at %0t ns, out_wr is not high", $time);
         end else begin
            $display("extra output word at %0t ns, out_wr is not low", $time);
         end
      end
   endtask

   task automatic check_outputs();
      check_valid(out_wr, exp_wr);
      if (exp_wr) begin
         check_ctrl(out_ctrl, exp_ctrl);
         check_data(out_data, exp_data);
      end
   endtask

   //////////////////////////////
   // drivers, falling edge
   //////////////////////////////
   task automatic send_word(input ctrl_t ctrl, input data_word_t data,
                            input data_word_t expected);
      @(negedge clk);
      check_outputs();
      in_wr       = 1'b1;
      in_ctrl     = ctrl;
      in_data     = data;
      rd_dst_addr = 1'b0;
      exp_wr      = 1'b1;
      exp_ctrl    = ctrl;
      exp_data    = expected;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge clk);
         check_outputs();
         in_wr       = 1'b0;
         in_ctrl     = '0;
         in_data     = '0;
         rd_dst_addr = 1'b0;
         exp_wr      = 1'b0;
      end
   endtask

   // queue region starts at q * 4k words
   task automatic send_config(input queue_idx_t q, input sram_addr_t cap);
      @(negedge clk);
      check_outputs();
      in_wr            = 1'b0;
      rd_dst_addr      = 1'b1;
      dst_oq           = q;
      dst_oq_low_addr  = sram_addr_t'(q) << 12;
      dst_oq_high_addr = (sram_addr_t'(q) << 12) + cap;
      exp_wr           = 1'b0;
   endtask

   //////////////////////////////
   // reference model
   //////////////////////////////
   function automatic int expected_share(input int q);
      int flows;
      int share;
      if (!model_live[q]) begin
         return 0;
      end
      flows = model_open_src[q] + model_open_dst[q] - model_close[q];
      if (flows < 1) begin
         flows = 1;
      end
      share = (int'(model_cap[q]) / 4) / flows;
      if (share < `FQ_MAX_PKT_WORDS) begin
         share = `FQ_MAX_PKT_WORDS;
      end
      return (share > 65535) ? 65535 : share;
   endfunction

   function automatic window_t expected_window(input int share);
      int bytes;
      bytes = share * `FQ_WORD_BYTES;
      return (bytes > 65535) ? 16'hFFFF : window_t'(bytes);
   endfunction

   // one's complement sum of three terms, folded
   function automatic window_t patched_checksum(input window_t old_win, input window_t new_win,
                                                input window_t old_ck);
      window_t inv_win;
      window_t inv_ck;
      window_t folded;
      int      sum;
      inv_win = ~old_win;
      inv_ck  = ~old_ck;
      sum = int'(inv_ck) + int'(inv_win) + int'(new_win);
      while (sum > 32'hFFFF) begin
         sum = (sum & 32'hFFFF) + (sum >> 16);
      end
      folded = sum[15:0];
      return ~folded;
   endfunction

   task automatic run_row(input row_t r);
      data_word_t  last_word;
      window_t     new_win;
      logic        web;
      logic        pure_ack;
      int          dq;
      if (r.kind == ROW_CFG) begin
         send_config(r.src, r.cap);
         if (r.cap != model_cap[r.src]) begin
            model_live[r.src] = 1'b1;
         end
         model_cap[r.src] = r.cap;
         idle_cycles(40);
      end else begin
         expand_row(r);
         web = (r.sport == 16'd80) || (r.sport == 16'd5001) ||
               (r.dport == 16'd80) || (r.dport == 16'd5001);
         pure_ack = r.flags[4] && !r.flags[0] && !r.flags[1] && !r.flags[2];
         new_win = expected_window(expected_share(int'(r.src)));
         last_word = pkt_data[7];
         if (r.kind == ROW_TCP && web && pure_ack && new_win != 16'h0000) begin
            last_word = {new_win, patched_checksum(r.window, new_win, r.checksum), r.tail};
         end
         for (int w = 0; w < 7; w++) begin
            send_word(pkt_ctrl[w], pkt_data[w], pkt_data[w]);
         end
         send_word(pkt_ctrl[7], pkt_data[7], last_word);
         // flow events only for single-destination web tcp
         if (r.kind == ROW_TCP && web && $countones(r.dst) == 1) begin
            dq = 0;
            for (int q = 0; q < `FQ_NUM_QUEUES; q++) begin
               if (r.dst[q]) begin
                  dq = q;
               end
            end
            if (r.flags[1] && r.flags[4]) begin
               model_open_src[r.src]++;
               model_open_dst[dq]++;
               model_live[r.src] = 1'b1;
               model_live[dq]    = 1'b1;
            end
            if (r.flags[0]) begin
               model_close[dq]++;
               model_live[dq] = 1'b1;
            end
         end
         // let the lane divider settle
         idle_cycles(30);
      end
   endtask

   //////////////////////////////
   // main sequence
   //////////////////////////////
   initial begin
      clk              = 1'b0;
      reset            = 1'b1;
      in_wr            = 1'b0;
      in_ctrl          = '0;
      in_data          = '0;
      rd_dst_addr      = 1'b0;
      dst_oq           = '0;
      dst_oq_high_addr = '0;
      dst_oq_low_addr  = '0;
      exp_wr           = 1'b0;
      exp_ctrl         = '0;
      exp_data         = '0;
      for (int q = 0; q < `FQ_NUM_QUEUES; q++) begin
         model_cap[q]      = '0;
         model_open_src[q] = 0;
         model_open_dst[q] = 0;
         model_close[q]    = 0;
         model_live[q]     = 1'b0;
      end
      void'($urandom(94));
      build_table();
      cycle_limit = rows.size() * 60;

      idle_cycles(2);
      reset = 1'b0;
      foreach (rows[i]) begin
         run_row(rows[i]);
      end
      // last pending word
      idle_cycles(1);

      $display("errors: data %0d, ctrl %0d, valid %0d", data_errors, ctrl_errors,
               valid_errors);
      if (data_errors == 0 && ctrl_errors == 0 && valid_errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* src/fairq_top.sv */
// fairq top: header parser, one lane per output queue, window rewriter
`timescale 1ns/1ps
`default_nettype none

`include "fairq_defines.svh"

module fairq_top (
   input  logic                   clk,
   input  logic                   reset,
   // packet stream in
   input  logic                   in_wr,
   input  fairq_pkg::ctrl_t       in_ctrl,
   input  fairq_pkg::data_word_t  in_data,
   // queue configuration strobe
   input  logic                   rd_dst_addr,
   input  fairq_pkg::queue_idx_t  dst_oq,
   input  fairq_pkg::sram_addr_t  dst_oq_high_addr,
   input  fairq_pkg::sram_addr_t  dst_oq_low_addr,
   // packet stream out
   output logic                   out_wr,
   output fairq_pkg::ctrl_t       out_ctrl,
   output fairq_pkg::data_word_t  out_data
);
   import fairq_pkg::*;

   queue_mask_t                       flow_open_src;
   queue_mask_t                       flow_open_dst;
   queue_mask_t                       flow_close;
   logic                              rewrite_word;
   queue_idx_t                        src_queue;
   share_t [`FQ_NUM_QUEUES-1:0]       shares;

   fairq_header_parser u_parser (
      .clk           (clk),
      .reset         (reset),
      .in_wr         (in_wr),
      .in_ctrl       (in_ctrl),
      .in_data       (in_data),
      .flow_open_src (flow_open_src),
      .flow_open_dst (flow_open_dst),
      .flow_close    (flow_close),
      .rewrite_word  (rewrite_word),
      .src_queue     (src_queue)
   );

   //////////////////////////////
   // one lane per output queue
   //////////////////////////////
   for (genvar q = 0; q < `FQ_NUM_QUEUES; q++) begin : g_lane
      fairq_queue_lane #(
         .LANE_INDEX (q)
      ) u_lane (
         .clk              (clk),
         .reset            (reset),
         .rd_dst_addr      (rd_dst_addr),
         .dst_oq           (dst_oq),
         .dst_oq_high_addr (dst_oq_high_addr),
         .dst_oq_low_addr  (dst_oq_low_addr),
         .flow_open_src    (flow_open_src[q]),
         .flow_open_dst    (flow_open_dst[q]),
         .flow_close       (flow_close[q]),
         .share            (shares[q])
      );
   end

   fairq_window_rewriter u_rewriter (
      .clk          (clk),
      .reset        (reset),
      .in_wr        (in_wr),
      .in_ctrl      (in_ctrl),
      .in_data      (in_data),
      .rewrite_word (rewrite_word),
      .src_queue    (src_queue),
      .shares       (shares),
      .out_wr       (out_wr),
      .out_ctrl     (out_ctrl),
      .out_data     (out_data)
   );

endmodule

`default_nettype wire

/* src/fairq_window_rewriter.sv */
// window rewriter: share select, new window, incremental checksum, output regs
`timescale 1ns/1ps
`default_nettype none

`include "fairq_defines.svh"

module fairq_window_rewriter (
   input  logic                                        clk,
   input  logic                                        reset,
   input  logic                                        in_wr,
   input  fairq_pkg::ctrl_t                            in_ctrl,
   input  fairq_pkg::data_word_t                       in_data,
   input  logic                                        rewrite_word,
   input  fairq_pkg::queue_idx_t                       src_queue,
   input  fairq_pkg::share_t [`FQ_NUM_QUEUES-1:0]      shares,
   output logic                                        out_wr,
   output fairq_pkg::ctrl_t                            out_ctrl,
   output fairq_pkg::data_word_t                       out_data
);
   import fairq_pkg::*;

   share_t       share_sel;
   logic [18:0]  win_bytes;
   window_t      new_window;
   window_t      old_window;
   window_t      old_checksum;
   window_t      window_diff;
   window_t      new_checksum;
   data_word_t   data_next;

   //////////////////////////////
   // new window from the share
   //////////////////////////////
   assign share_sel  = shares[src_queue];
   // share in words to bytes
   assign win_bytes  = {3'b000, share_sel} * 19'(`FQ_WORD_BYTES);
   assign new_window = (win_bytes > 19'(`FQ_MAX_WINDOW)) ? `FQ_MAX_WINDOW : win_bytes[15:0];

   // window and checksum sit in the top half of word 7
   assign old_window   = in_data[63:48];
   assign old_checksum = in_data[47:32];

   // rfc 1624 style update, hc' = ~(~hc + ~m + m')
   assign window_diff  = ones_add(~old_window, new_window);
   assign new_checksum = ~ones_add(window_diff, ~old_checksum);

   // zero share means the queue is not configured, leave the word alone
   assign data_next = (rewrite_word && new_window != '0) ?
                      {new_window, new_checksum, in_data[31:0]} : in_data;

   //////////////////////////////
   // output stage, one cycle
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         out_wr <= 1'b0;
      end else begin
         out_wr <= in_wr;
      end
   end

   always_ff @(posedge clk) begin
      out_ctrl <= in_ctrl;
      out_data <= data_next;
   end

endmodule

`default_nettype wire

/* src/fairq_queue_lane.sv */
// queue lane: capacity register, flow counters, restoring fair-share divider
`timescale 1ns/1ps
`default_nettype none

`include "fairq_defines.svh"

module fairq_queue_lane #(
   parameter int LANE_INDEX = 0
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   rd_dst_addr,
   input  fairq_pkg::queue_idx_t  dst_oq,
   input  fairq_pkg::sram_addr_t  dst_oq_high_addr,
   input  fairq_pkg::sram_addr_t  dst_oq_low_addr,
   input  logic                   flow_open_src,
   input  logic                   flow_open_dst,
   input  logic                   flow_close,
   output fairq_pkg::share_t      share
);
   import fairq_pkg::*;

   // quotient width, one step per cycle
   localparam int DIV_BITS = 20;

   sram_addr_t           capacity;
   sram_addr_t           new_capacity;
   logic                 cap_write;
   flow_count_t          open_src_count;
   flow_count_t          open_dst_count;
   flow_count_t          close_count;
   flow_count_t          open_count;
   logic [16:0]          flow_diff;
   flow_count_t          flow_count;
   logic                 start;
   logic                 busy;
   logic [4:0]           step_count;
   logic [DIV_BITS-1:0]  quotient;
   logic [DIV_BITS-1:0]  quotient_next;
   flow_count_t          remainder;
   flow_count_t          remainder_next;
   flow_count_t          divisor;
   logic [16:0]          partial;
   share_t               share_next;

   //////////////////////////////
   // capacity and flow counts
   //////////////////////////////
   assign cap_write    = rd_dst_addr && (dst_oq == queue_idx_t'(LANE_INDEX));
   assign new_capacity = dst_oq_high_addr - dst_oq_low_addr;

   // active flows, never below one
   assign open_count = open_src_count + open_dst_count;
   assign flow_diff  = {1'b0, open_count} - {1'b0, close_count};
   assign flow_count = (!flow_diff[16] && flow_diff != '0) ? flow_diff[15:0] : 16'd1;

   always_ff @(posedge clk) begin
      if (reset) begin
         capacity       <= '0;
         open_src_count <= '0;
         open_dst_count <= '0;
         close_count    <= '0;
         start          <= 1'b0;
      end else begin
         if (cap_write) begin
            capacity <= new_capacity;
         end
         if (flow_open_src) begin
            open_src_count <= open_src_count + 1'b1;
         end
         if (flow_open_dst) begin
            open_dst_count <= open_dst_count + 1'b1;
         end
         if (flow_close) begin
            close_count <= close_count + 1'b1;
         end
         // kick the divider the cycle after any change
         start <= (cap_write && new_capacity != capacity) ||
                  flow_open_src || flow_open_dst || flow_close;
      end
   end

   //////////////////////////////
   // restoring divider
   //////////////////////////////
   always_comb begin
      partial = {remainder, quotient[DIV_BITS-1]};
      if (partial >= {1'b0, divisor}) begin
         remainder_next = flow_count_t'(partial - {1'b0, divisor});
         quotient_next  = {quotient[DIV_BITS-2:0], 1'b1};
      end else begin
         remainder_next = partial[15:0];
         quotient_next  = {quotient[DIV_BITS-2:0], 1'b0};
      end
      // floor at the minimum share, clip to 16 bits
      if (quotient_next < DIV_BITS'(`FQ_MAX_PKT_WORDS)) begin
         share_next = share_t'(`FQ_MAX_PKT_WORDS);
      end else if (quotient_next > DIV_BITS'(16'hFFFF)) begin
         share_next = 16'hFFFF;
      end else begin
         share_next = quotient_next[15:0];
      end
   end

   // step counter, a new start restarts the division
   always_ff @(posedge clk) begin
      if (reset) begin
         busy       <= 1'b0;
         step_count <= '0;
         share      <= '0;
      end else if (start) begin
         busy       <= 1'b1;
         step_count <= '0;
      end else if (busy) begin
         step_count <= step_count + 1'b1;
         if (step_count == 5'(DIV_BITS - 1)) begin
            busy  <= 1'b0;
            share <= share_next;
         end
      end
   end

   // operands sampled at start, quarter of the capacity over the flows
   always_ff @(posedge clk) begin
      if (start) begin
         quotient  <= DIV_BITS'(capacity >> 2);
         remainder <= '0;
         divisor   <= flow_count;
      end else if (busy) begin
         quotient  <= quotient_next;
         remainder <= remainder_next;
      end
   end

endmodule

`default_nettype wire

/* src/fairq_header_parser.sv */
// header parser: per-packet word FSM, flow open/close events, rewrite strobe
`timescale 1ns/1ps
`default_nettype none

`include "fairq_defines.svh"

module fairq_header_parser (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    in_wr,
   input  fairq_pkg::ctrl_t        in_ctrl,
   input  fairq_pkg::data_word_t   in_data,
   output fairq_pkg::queue_mask_t  flow_open_src,
   output fairq_pkg::queue_mask_t  flow_open_dst,
   output fairq_pkg::queue_mask_t  flow_close,
   output logic                    rewrite_word,
   output fairq_pkg::queue_idx_t   src_queue
);
   import fairq_pkg::*;

   parse_state_t  state;
   parse_state_t  state_next;
   queue_mask_t   dst_mask;
   queue_mask_t   src_mask;
   logic          single_dest;
   logic          web_port;
   logic          word_6_seen;

   // header fields, each valid only in its own word
   logic [15:0]   ether_type;
   logic [7:0]    ip_proto;
   logic [15:0]   tcp_src_port;
   logic [15:0]   tcp_dst_port;
   logic          tcp_fin;
   logic          tcp_syn;
   logic          tcp_rst;
   logic          tcp_ack;

   //////////////////////////////
   // field slices
   //////////////////////////////
   assign ether_type   = in_data[31:16];
   assign ip_proto     = in_data[7:0];
   assign tcp_src_port = in_data[47:32];
   assign tcp_dst_port = in_data[31:16];
   assign tcp_fin      = in_data[0];
   assign tcp_syn      = in_data[1];
   assign tcp_rst      = in_data[2];
   assign tcp_ack      = in_data[4];

   // http or iperf on either side
   assign web_port = (tcp_src_port == `FQ_PORT_HTTP) || (tcp_src_port == `FQ_PORT_IPERF) ||
                     (tcp_dst_port == `FQ_PORT_HTTP) || (tcp_dst_port == `FQ_PORT_IPERF);

   // exactly one destination bit, multicast is not counted
   assign single_dest = (dst_mask != '0) && ((dst_mask & (dst_mask - 1'b1)) == '0);
   assign src_mask    = queue_mask_t'(1) << src_queue;

   //////////////////////////////
   // next state
   //////////////////////////////
   always_comb begin
      state_next = state;
      if (in_wr) begin
         case (state)
            CTRL_WORD: begin
               if (in_ctrl == `FQ_IOQ_CTRL) begin
                  state_next = WORD_1;
               end
            end
            WORD_1:  state_next = WORD_2;
            WORD_2:  state_next = (ether_type == `FQ_ETHERTYPE_IP) ? WORD_3 : WAIT_EOP;
            WORD_3:  state_next = (ip_proto == `FQ_PROTO_TCP) ? WORD_4 : WAIT_EOP;
            WORD_4:  state_next = WORD_5;
            WORD_5:  state_next = web_port ? WORD_6 : WAIT_EOP;
            // only a pure ack goes on to the window word
            WORD_6:  state_next = (tcp_ack && !tcp_syn && !tcp_fin && !tcp_rst) ?
                                  WORD_7 : WAIT_EOP;
            WORD_7:  state_next = WAIT_EOP;
            WAIT_EOP: state_next = WAIT_EOP;
            default: state_next = CTRL_WORD;
         endcase
         // last word of any packet ends the walk
         if (state != CTRL_WORD && in_ctrl != '0) begin
            state_next = CTRL_WORD;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= CTRL_WORD;
      end else begin
         state <= state_next;
      end
   end

   // ports from the module header, held for the rest of the packet
   always_ff @(posedge clk) begin
      if (in_wr && state == CTRL_WORD && in_ctrl == `FQ_IOQ_CTRL) begin
         src_queue <= in_data[`FQ_IOQ_SRC_POS +: $bits(queue_idx_t)];
         dst_mask  <= in_data[`FQ_IOQ_DST_POS +: `FQ_NUM_QUEUES];
      end
   end

   //////////////////////////////
   // flow events, same cycle as word 6
   //////////////////////////////
   assign word_6_seen = in_wr && (state == WORD_6) && single_dest;

   // syn-ack opens on both ends, fin closes on the destination
   assign flow_open_src = (word_6_seen && tcp_syn && tcp_ack) ? src_mask : '0;
   assign flow_open_dst = (word_6_seen && tcp_syn && tcp_ack) ? dst_mask : '0;
   assign flow_close    = (word_6_seen && tcp_fin) ? dst_mask : '0;

   // window word of a qualifying ack is on the input now
   assign rewrite_word = in_wr && (state == WORD_7);

endmodule

`default_nettype wire

/* src/fairq_pkg.sv */
// shared types and the one's-complement add used by the checksum patch
`default_nettype none

`include "fairq_defines.svh"

package fairq_pkg;

   // stream word and its control byte
   typedef logic [`FQ_DATA_WIDTH-1:0]              data_word_t;
   typedef logic [`FQ_CTRL_WIDTH-1:0]              ctrl_t;

   // queue numbering, binary and one-hot
   typedef logic [$clog2(`FQ_NUM_QUEUES)-1:0]      queue_idx_t;
   typedef logic [`FQ_NUM_QUEUES-1:0]              queue_mask_t;

   // queue address, also used for capacity in words
   typedef logic [`FQ_SRAM_ADDR_WIDTH-1:0]         sram_addr_t;

   typedef logic [15:0]                            flow_count_t;
   typedef logic [15:0]                            share_t;
   // tcp window or checksum field
   typedef logic [15:0]                            window_t;

   // one-hot header walk, one state per word position
   typedef enum logic [8:0] {
      CTRL_WORD = 9'b0_0000_0001,
      WORD_1    = 9'b0_0000_0010,
      WORD_2    = 9'b0_0000_0100,
      WORD_3    = 9'b0_0000_1000,
      WORD_4    = 9'b0_0001_0000,
      WORD_5    = 9'b0_0010_0000,
      WORD_6    = 9'b0_0100_0000,
      WORD_7    = 9'b0_1000_0000,
      WAIT_EOP  = 9'b1_0000_0000
   } parse_state_t;

   // 16-bit add with end-around carry
   function automatic window_t ones_add(input window_t a, input window_t b);
      logic [16:0] sum;
      sum = {1'b0, a} + {1'b0, b};
      // low half is at most FFFE when the carry is set, so no second wrap
      return sum[15:0] + window_t'(sum[16]);
   endfunction

endpackage

`default_nettype wire

/* src/fairq_defines.svh */
// stream widths, header field positions, protocol constants, window limits
`ifndef FAIRQ_DEFINES_SVH
`define FAIRQ_DEFINES_SVH

//////////////////////////////
// stream and queue widths
//////////////////////////////
`define FQ_DATA_WIDTH       64
`define FQ_CTRL_WIDTH       8
`define FQ_NUM_QUEUES       8
`define FQ_SRAM_ADDR_WIDTH  19

//////////////////////////////
// module header word
//////////////////////////////
// ctrl value of the io queue header word
`define FQ_IOQ_CTRL         8'hFF
// binary source port, one-hot destination mask
`define FQ_IOQ_SRC_POS      16
`define FQ_IOQ_DST_POS      0

//////////////////////////////
// protocol constants
//////////////////////////////
`define FQ_ETHERTYPE_IP     16'h0800
`define FQ_PROTO_TCP        8'd6
`define FQ_PORT_HTTP        16'd80
`define FQ_PORT_IPERF       16'd5001

// window math
`define FQ_WORD_BYTES       8
// floor on the per-queue share, in words
`define FQ_MAX_PKT_WORDS    256
`define FQ_MAX_WINDOW       16'hFFFF

`endif
